// File: src/motorCfgPkg.sv
`default_nettype none

package motorCfgPkg;

    // width of the PWM period setting
    localparam int PWM_LEN_W = 12;

    // duty, remainder and lost-width accumulators
    localparam int DUTY_W = 16;

    // step length and in-step cycle count
    localparam int STEP_LEN_W = 25;

    // shortest pulse the gate drivers can switch cleanly
    localparam int MIN_PULSE = 16;

    // forced-off cycles on every commutation step change
    localparam int DEAD_CYCLES = 2;

    // steps in one electrical cycle
    localparam int STEP_COUNT = 12;

endpackage

`default_nettype wire

// File: src/motorStepPkg.sv
`default_nettype none

package motorStepPkg;

    typedef logic [3:0] stepNum_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_FINISH
    } seqState_t;

    // phase index 0..2 that carries the pwm in this step
    function automatic logic [1:0] phaseOf(input stepNum_t step);
        return 2'(step % 3);
    endfunction

    // first half of the cycle drives the high switches
    function automatic logic highSide(input stepNum_t step);
        return step < stepNum_t'(motorCfgPkg::STEP_COUNT / 2);
    endfunction

endpackage

`default_nettype wire

// File: src/stepTimeIf.sv
`default_nettype none

interface stepTimeIf;
    import motorStepPkg::*;

    stepNum_t sgStep;
    // one-cycle strobes at the step edges
    logic     stepFirst2;
    logic     stepFirst1;
    logic     stepLast2;
    logic     stepLast1;
    // levels from the sequencer
    logic     pwmActive;
    logic     pwmLastStep;

    modport timer (
        output stepFirst2, stepFirst1, stepLast2, stepLast1,
        input  pwmActive
    );

    modport seq (
        input  stepFirst2, stepFirst1, stepLast2, stepLast1,
        output sgStep, pwmActive, pwmLastStep
    );

    modport gen (
        input sgStep, stepFirst2, stepFirst1, stepLast2, stepLast1,
        input pwmActive, pwmLastStep
    );

endinterface

`default_nettype wire

// File: src/stepTimer.sv
`default_nettype none

module stepTimer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [motorCfgPkg::STEP_LEN_W-1:0]  stepLen,
    stepTimeIf.timer                            tm
);
    import motorCfgPkg::*;

    logic [STEP_LEN_W-1:0] stepCnt;
    logic [STEP_LEN_W-1:0] lastCnt;
    logic [STEP_LEN_W-1:0] lastCnt1;

    assign lastCnt  = stepLen - STEP_LEN_W'(1);
    assign lastCnt1 = stepLen - STEP_LEN_W'(2);

    // in-step cycle count, parked at zero while the drive is idle
    always_ff @(posedge clk) begin
        if (rst) begin
            stepCnt <= '0;
        end else if (!tm.pwmActive) begin
            stepCnt <= '0;
        end else if (stepCnt == lastCnt) begin
            stepCnt <= '0;
        end else begin
            stepCnt <= stepCnt + STEP_LEN_W'(1);
        end
    end

    // edge strobes, first2/first1 open the step and last1/last2 close it
    assign tm.stepFirst2 = tm.pwmActive && (stepCnt == '0);
    assign tm.stepFirst1 = tm.pwmActive && (stepCnt == STEP_LEN_W'(1));
    assign tm.stepLast1  = tm.pwmActive && (stepCnt == lastCnt1);
    assign tm.stepLast2  = tm.pwmActive && (stepCnt == lastCnt);

endmodule

`default_nettype wire

// File: src/stepSequencer.sv
`default_nettype none

module stepSequencer (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    stop,
    output logic    busy,
    stepTimeIf.seq  sq
);
    import motorCfgPkg::*;
    import motorStepPkg::*;

    seqState_t state;
    stepNum_t  step;
    logic      lastStep;
    stepNum_t  nextStep;

    assign lastStep = (step == stepNum_t'(STEP_COUNT - 1));
    assign nextStep = lastStep ? '0 : step + stepNum_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            step  <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state <= SEQ_RUN;
                        step  <= '0;
                    end
                end
                SEQ_RUN: begin
                    if (sq.stepLast2) begin
                        step <= nextStep;
                    end
                    if (stop) begin
                        state <= SEQ_FINISH;
                    end
                end
                default: begin
                    // finish the cycle, drop out after step 11
                    if (sq.stepLast2) begin
                        step <= nextStep;
                        if (lastStep) begin
                            state <= SEQ_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    assign sq.sgStep      = step;
    assign sq.pwmActive   = (state != SEQ_IDLE);
    assign sq.pwmLastStep = (state == SEQ_FINISH) && lastStep;
    assign busy           = (state != SEQ_IDLE);

endmodule

`default_nettype wire

// File: src/pwmGenerator.sv
`default_nettype none

module pwmGenerator (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [motorCfgPkg::PWM_LEN_W-1:0]   pwmLen,
    input  logic [motorCfgPkg::DUTY_W-1:0]      duty,
    stepTimeIf.gen                              gn,
    output logic                                pwm,
    output logic [motorCfgPkg::DUTY_W-1:0]      posLost
);
    import motorCfgPkg::*;

    logic [PWM_LEN_W-1:0] pwmCnt;
    logic                 reload;
    logic [DUTY_W-1:0]    remain;
    logic [DUTY_W-1:0]    posSum;
    logic                 pulseOk;
    logic [DUTY_W-1:0]    pulseCnt;
    logic [DUTY_W-1:0]    wantAcc;
    logic [DUTY_W-1:0]    realAcc;
    logic [DUTY_W-1:0]    wantInc;
    logic [DUTY_W-1:0]    realInc;
    logic [DUTY_W-1:0]    wantStep;
    logic [DUTY_W-1:0]    realStep;
    logic [DUTY_W-1:0]    lostDiff;

    assign reload  = gn.pwmActive && (pwmCnt == PWM_LEN_W'(1));
    assign posSum  = remain + duty;
    assign pulseOk = (posSum >= DUTY_W'(MIN_PULSE));

    // period counter, realigned one cycle before each step boundary
    // except in the last step where no next step follows
    always_ff @(posedge clk) begin
        if (rst || !gn.pwmActive) begin
            pwmCnt <= pwmLen;
        end else if (gn.stepLast1 && !gn.pwmLastStep) begin
            pwmCnt <= pwmLen;
        end else if (reload) begin
            pwmCnt <= pwmLen;
        end else begin
            pwmCnt <= pwmCnt - PWM_LEN_W'(1);
        end
    end

    // a too short pulse is held back and its width carried forward
    always_ff @(posedge clk) begin
        if (rst || !gn.pwmActive) begin
            remain <= '0;
        end else if (reload) begin
            remain <= pulseOk ? '0 : posSum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !gn.pwmActive) begin
            pulseCnt <= '0;
        end else if (gn.stepLast2) begin
            pulseCnt <= '0;
        end else if (reload && pulseOk) begin
            pulseCnt <= posSum;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - DUTY_W'(1);
        end
    end

    assign pwm = (pulseCnt != '0);

    // wanted vs real width inside the current step
    assign wantInc = reload ? duty : '0;
    assign realInc = DUTY_W'(pwm);

    always_ff @(posedge clk) begin
        if (rst || !gn.pwmActive) begin
            wantAcc <= '0;
            realAcc <= '0;
        end else if (gn.stepLast2) begin
            wantAcc <= '0;
            realAcc <= '0;
        end else begin
            wantAcc <= wantAcc + wantInc;
            realAcc <= realAcc + realInc;
        end
    end

    // step totals, taken with the closing cycle included
    always_ff @(posedge clk) begin
        if (gn.stepLast2) begin
            wantStep <= wantAcc + wantInc;
            realStep <= realAcc + realInc;
        end
    end

    assign lostDiff = wantStep - realStep;

    always_ff @(posedge clk) begin
        if (rst) begin
            posLost <= '0;
        end else if (gn.stepFirst2) begin
            posLost <= lostDiff[DUTY_W-1] ? (~lostDiff + DUTY_W'(1)) : lostDiff;
        end
    end

endmodule

`default_nettype wire

// File: src/phaseDriver.sv
`default_nettype none

module phaseDriver (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pwm,
    input  motorStepPkg::stepNum_t  sgStep,
    output logic [2:0]              hiSide,
    output logic [2:0]              loSide
);
    import motorCfgPkg::*;
    import motorStepPkg::*;

    localparam int DEAD_W = $clog2(DEAD_CYCLES + 1);

    stepNum_t         prevStep;
    logic             stepChange;
    logic [DEAD_W-1:0] deadCnt;
    logic             forceOff;
    logic [2:0]       phaseSel;

    assign stepChange = (sgStep != prevStep);
    assign forceOff   = stepChange || (deadCnt != '0);
    assign phaseSel   = 3'b001 << phaseOf(sgStep);

    // dead time starts in the cycle the new step appears
    always_ff @(posedge clk) begin
        if (rst) begin
            prevStep <= '0;
            deadCnt  <= '0;
        end else begin
            prevStep <= sgStep;
            if (stepChange) begin
                deadCnt <= DEAD_W'(DEAD_CYCLES - 1);
            end else if (deadCnt != '0) begin
                deadCnt <= deadCnt - DEAD_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hiSide <= '0;
            loSide <= '0;
        end else begin
            hiSide <= (pwm && !forceOff && highSide(sgStep)) ? phaseSel : 3'b000;
            loSide <= (pwm && !forceOff && !highSide(sgStep)) ? phaseSel : 3'b000;
        end
    end

endmodule

`default_nettype wire

// File: src/motorTop.sv
`default_nettype none

module motorTop (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic                                stop,
    input  logic [motorCfgPkg::STEP_LEN_W-1:0]  stepLen,
    input  logic [motorCfgPkg::PWM_LEN_W-1:0]   pwmLen,
    input  logic [motorCfgPkg::DUTY_W-1:0]      duty,
    output logic                                busy,
    output logic                                pwm,
    output logic [3:0]                          sgStep,
    output logic [2:0]                          hiSide,
    output logic [2:0]                          loSide,
    output logic [motorCfgPkg::DUTY_W-1:0]      posLost
);

    stepTimeIf stepIf ();

    stepTimer u_stepTimer (
        .clk     (clk),
        .rst     (rst),
        .stepLen (stepLen),
        .tm      (stepIf.timer)
    );

    stepSequencer u_stepSequencer (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .stop  (stop),
        .busy  (busy),
        .sq    (stepIf.seq)
    );

    pwmGenerator u_pwmGenerator (
        .clk     (clk),
        .rst     (rst),
        .pwmLen  (pwmLen),
        .duty    (duty),
        .gn      (stepIf.gen),
        .pwm     (pwm),
        .posLost (posLost)
    );

    // switches follow the generator output one cycle later
    phaseDriver u_phaseDriver (
        .clk    (clk),
        .rst    (rst),
        .pwm    (pwm),
        .sgStep (stepIf.sgStep),
        .hiSide (hiSide),
        .loSide (loSide)
    );

    assign sgStep = stepIf.sgStep;

endmodule

`default_nettype wire

// File: verif/tbClock.sv
`default_nettype none

module tbClock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: verif/motorTop_checker.sv
`default_nettype none

module motorTop_checker (
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic [3:0] sgStep,
    input logic [2:0] hiSide,
    input logic [2:0] loSide
);
    import motorStepPkg::*;

    int       failCount = 0;
    stepNum_t stepSeen;

    // step that the registered switch pattern was chosen from
    always_ff @(posedge clk) begin
        stepSeen <= sgStep;
    end

    noShootThrough: assert property (@(posedge clk) disable iff (rst)
        (hiSide & loSide) == 3'b000)
    else begin
        failCount++;
        $error("high and low switch of one phase are on together");
    end

    atMostOneSwitch: assert property (@(posedge clk) disable iff (rst)
        $onehot0({hiSide, loSide}))
    else begin
        failCount++;
        $error("more than one switch is on");
    end

    // the active switch sits on the phase and side of its step
    switchOnStepPhase: assert property (@(posedge clk) disable iff (rst)
        (hiSide | loSide) != 3'b000 |->
            ((hiSide | loSide) == (3'b001 << phaseOf(stepSeen)))
            && ((hiSide != 3'b000) == highSide(stepSeen)))
    else begin
        failCount++;
        $error("switch does not match the phase or side of the step");
    end

    resetLeavesIdle: assert property (@(posedge clk) rst |=> !busy)
    else begin
        failCount++;
        $error("busy is set one cycle after reset");
    end

endmodule

bind motorTop motorTop_checker u_motorTopChecker (
    .clk    (clk),
    .rst    (rst),
    .busy   (busy),
    .sgStep (sgStep),
    .hiSide (hiSide),
    .loSide (loSide)
);

`default_nettype wire

// File: verif/motorTb.sv
`default_nettype none

module motorTb;
    import motorCfgPkg::*;
    import motorStepPkg::*;

    localparam int RUNS         = 6;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  stop;
    logic [STEP_LEN_W-1:0] stepLen;
    logic [PWM_LEN_W-1:0]  pwmLen;
    logic [DUTY_W-1:0]     duty;
    logic                  busy;
    logic                  pwm;
    logic [3:0]            sgStep;
    logic [2:0]            hiSide;
    logic [2:0]            loSide;
    logic [DUTY_W-1:0]     posLost;

    // reference model state, one update per rising edge
    seqState_t mState = SEQ_IDLE;
    int        mStep;
    int        mCnt;
    int        mPeriod;
    int        mRemain;
    int        mPulse;
    int        mWant;
    int        mReal;
    int        mWantStep;
    int        mRealStep;
    int        mLost;
    int        mPrev;
    int        mDead;
    int        mHi;
    int        mLo;
    bit        wantKnown = 1'b0;
    bit        lostKnown = 1'b1;

    string curTest;
    int    errors;
    int    testStart;
    int    testsRun;
    int    testsFailed;
    int    budget;
    int    runStep[RUNS];
    int    runPwm[RUNS];
    int    runDuty[RUNS];
    int    runCycles[RUNS];

    tbClock #(.PERIOD(CLK_PERIOD)) u_tbClock (.clk(clk));

    motorTop u_motorTop (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .stop    (stop),
        .stepLen (stepLen),
        .pwmLen  (pwmLen),
        .duty    (duty),
        .busy    (busy),
        .pwm     (pwm),
        .sgStep  (sgStep),
        .hiSide  (hiSide),
        .loSide  (loSide),
        .posLost (posLost)
    );

    always @(posedge clk) begin : refModel
        bit act;
        bit first2;
        bit last1;
        bit last2;
        bit finalStep;
        bit reload;
        bit pulseHigh;
        bit gap;
        int sum;
        int sl;
        int diff;

        sl        = int'(stepLen);
        act       = (mState != SEQ_IDLE);
        first2    = act && (mCnt == 0);
        last1     = act && (mCnt == sl - 2);
        last2     = act && (mCnt == sl - 1);
        finalStep = (mState == SEQ_FINISH) && (mStep == STEP_COUNT - 1);
        reload    = act && (mPeriod == 1);
        sum       = mRemain + int'(duty);
        pulseHigh = (mPulse != 0);
        gap       = (mStep != mPrev) || (mDead != 0);
        if (rst) begin
            mState  = SEQ_IDLE;
            mStep   = 0;
            mCnt    = 0;
            mPeriod = int'(pwmLen);
            mRemain = 0;
            mPulse  = 0;
            mWant   = 0;
            mReal   = 0;
            mLost   = 0;
            mPrev   = 0;
            mDead   = 0;
            mHi     = 0;
            mLo     = 0;
            lostKnown = 1'b1;
        end else begin
            // switches trail pwm by one cycle and go dark on a step change
            mHi = 0;
            mLo = 0;
            if (pulseHigh && !gap) begin
                if (mStep < STEP_COUNT / 2) begin
                    mHi = 1 << (mStep % 3);
                end else begin
                    mLo = 1 << (mStep % 3);
                end
            end
            if (mStep != mPrev) begin
                mDead = DEAD_CYCLES - 1;
            end else if (mDead != 0) begin
                mDead = mDead - 1;
            end
            mPrev = mStep;
            if (first2) begin
                diff = mWantStep - mRealStep;
                mLost = (diff < 0) ? -diff : diff;
                lostKnown = wantKnown;
            end
            if (last2) begin
                mWantStep = mWant + (reload ? int'(duty) : 0);
                mRealStep = mReal + int'(pulseHigh);
                wantKnown = 1'b1;
            end
            if (!act || last2) begin
                mWant = 0;
                mReal = 0;
            end else begin
                mWant = mWant + (reload ? int'(duty) : 0);
                mReal = mReal + int'(pulseHigh);
            end
            // short pulses are held back and carried into the next period
            if (!act) begin
                mRemain = 0;
            end else if (reload) begin
                mRemain = (sum >= MIN_PULSE) ? 0 : sum;
            end
            if (!act || last2) begin
                mPulse = 0;
            end else if (reload && sum >= MIN_PULSE) begin
                mPulse = sum;
            end else if (mPulse != 0) begin
                mPulse = mPulse - 1;
            end
            if (!act || (last1 && !finalStep) || reload) begin
                mPeriod = int'(pwmLen);
            end else begin
                mPeriod = mPeriod - 1;
            end
            case (mState)
                SEQ_IDLE: begin
                    if (start) begin
                        mState = SEQ_RUN;
                        mStep  = 0;
                    end
                end
                SEQ_RUN: begin
                    if (last2) begin
                        mStep = (mStep + 1) % STEP_COUNT;
                    end
                    if (stop) begin
                        mState = SEQ_FINISH;
                    end
                end
                default: begin
                    if (last2) begin
                        if (mStep == STEP_COUNT - 1) begin
                            mState = SEQ_IDLE;
                        end
                        mStep = (mStep + 1) % STEP_COUNT;
                    end
                end
            endcase
            if (!act || mCnt == sl - 1) begin
                mCnt = 0;
            end else begin
                mCnt = mCnt + 1;
            end
        end
    end

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error %s %s: expected %0d, actual %0d", curTest, what, expected, actual);
        end
    endtask

    task automatic checkOutputs();
        compare("busy", 32'(mState != SEQ_IDLE), 32'(busy));
        compare("pwm", 32'(mPulse != 0), 32'(pwm));
        compare("sgStep", mStep, 32'(sgStep));
        compare("hiSide", mHi, 32'(hiSide));
        compare("loSide", mLo, 32'(loSide));
        // first report after power-up covers no finished step
        if (lostKnown) begin
            compare("posLost", mLost, 32'(posLost));
        end
    endtask

    // outputs are sampled on the falling edge, then inputs may change
    task automatic cycle();
        @(negedge clk);
        checkOutputs();
    endtask

    task automatic endTest();
        int bad;
        bad = errors - testStart;
        testsRun++;
        if (bad == 0) begin
            $display("test %s: ok", curTest);
        end else begin
            testsFailed++;
            $display("test %s: %0d mismatches", curTest, bad);
        end
    endtask

    task automatic runDrive(input int idx);
        int lastSeen;
        testStart = errors;
        cycle();
        stepLen = STEP_LEN_W'(runStep[idx]);
        pwmLen  = PWM_LEN_W'(runPwm[idx]);
        duty    = DUTY_W'(runDuty[idx]);
        start   = 1'b1;
        cycle();
        start = 1'b0;
        repeat (runCycles[idx]) cycle();
        stop = 1'b1;
        cycle();
        stop = 1'b0;
        lastSeen = int'(sgStep);
        while (busy === 1'b1) begin
            lastSeen = int'(sgStep);
            cycle();
        end
        compare("final step", STEP_COUNT - 1, lastSeen);
        repeat (4) cycle();
        endTest();
    endtask

    initial begin : watchdog
        wait (budget > 0);
        #(budget * CLK_PERIOD);
        $display("watchdog: run did not end within %0d cycles", budget);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : mainSeq
        int total;
        int checkerFails;
        void'($urandom(75));
        rst     = 1'b1;
        start   = 1'b1;
        stop    = 1'b0;
        stepLen = STEP_LEN_W'(8);
        pwmLen  = PWM_LEN_W'(8);
        duty    = '0;
        // all runs are drawn up front so the watchdog can be sized
        total = 2 * RESET_CYCLES + 20;
        for (int i = 0; i < RUNS; i++) begin
            if (i < RUNS / 2) begin
                // period longer than the pulse so the falling edge shows
                runDuty[i] = $urandom_range(MIN_PULSE + 15, MIN_PULSE);
                runPwm[i]  = $urandom_range(MIN_PULSE + 32, MIN_PULSE + 16);
            end else begin
                runDuty[i] = $urandom_range(MIN_PULSE - 1, 1);
                runPwm[i]  = $urandom_range(16, 4);
            end
            // room for at least one full period per step
            runStep[i]   = $urandom_range(6 * runPwm[i], runPwm[i] + 8);
            runCycles[i] = $urandom_range(24 * runStep[i], 12 * runStep[i]);
            total += runCycles[i] + 13 * runStep[i] + 10;
        end
        budget = total;

        // start is held high through reset and must have no effect
        curTest   = "reset";
        testStart = errors;
        @(posedge clk);
        repeat (RESET_CYCLES) cycle();
        rst   = 1'b0;
        start = 1'b0;
        repeat (5) cycle();
        compare("busy after reset", 0, 32'(busy));
        endTest();

        for (int i = 0; i < RUNS; i++) begin
            if (i < RUNS / 2) begin
                curTest = $sformatf("pulse%0d", i);
            end else begin
                curTest = $sformatf("carry%0d", i);
            end
            runDrive(i);
        end

        checkerFails = u_motorTop.u_motorTopChecker.failCount;
        $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, checkerFails);
        if (testsFailed == 0 && errors == 0 && checkerFails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/motorCfgPkg.sv
src/motorStepPkg.sv
src/stepTimeIf.sv
src/stepTimer.sv
src/stepSequencer.sv
src/pwmGenerator.sv
src/phaseDriver.sv
src/motorTop.sv
verif/tbClock.sv
verif/motorTop_checker.sv
verif/motorTb.sv

// File: Makefile
# Verilator build and run of the motor drive testbench

VERILATOR ?= verilator
TOP       ?= motorTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
